// ==== src/lane_pkg.sv ====
`default_nettype none

package lane_pkg;

	////////////////////////////////////////////////////////////
	// basic types
	////////////////////////////////////////////////////////////

	typedef logic [10:0] coord_t;

	typedef struct packed {
		coord_t hcount;
		coord_t vcount;
		logic   blank;
	} pixel_req_t;

	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [1:0] blue;
	} rgb_t;

	typedef enum logic [1:0] {
		game_idle,
		game_play,
		game_over
	} game_state_e;

	typedef struct packed {
		logic   active;
		coord_t lane_x;
		coord_t top;
	} obstacle_t;

	localparam int num_digits = 4;

	// digit 0 is the least significant
	typedef logic [num_digits-1:0][3:0] bcd_score_t;

	////////////////////////////////////////////////////////////
	// layout
	////////////////////////////////////////////////////////////

	localparam int num_slots = 3;

	localparam coord_t lane_x_0 = 11'd195;
	localparam coord_t lane_x_1 = 11'd295;
	localparam coord_t lane_x_2 = 11'd395;

	localparam coord_t car_width       = 11'd50;
	localparam coord_t obstacle_height = 11'd70;
	localparam coord_t obstacle_step   = 11'd5;
	localparam coord_t retire_top      = 11'd455;
	localparam coord_t handoff_top     = 11'd170;
	localparam coord_t player_top      = 11'd420;
	localparam coord_t player_bottom   = 11'd470;
	localparam coord_t steer_step      = 11'd5;

	// frame ticks between obstacle steps
	localparam int frames_per_step = 2;
	localparam int frame_div_width = $clog2(frames_per_step + 1);

	localparam coord_t road_left        = 11'd170;
	localparam coord_t road_right       = 11'd470;
	localparam coord_t divider_0_left   = 11'd265;
	localparam coord_t divider_0_right  = 11'd275;
	localparam coord_t divider_1_left   = 11'd365;
	localparam coord_t divider_1_right  = 11'd375;

	// score digits, most significant at digit_x0
	localparam coord_t digit_x0     = 11'd10;
	localparam coord_t digit_pitch  = 11'd20;
	localparam coord_t digit_top    = 11'd10;
	localparam coord_t digit_height = 11'd20;
	localparam coord_t digit_width  = 11'd10;

	////////////////////////////////////////////////////////////
	// colours
	////////////////////////////////////////////////////////////

	localparam rgb_t colour_black      = '{red: 3'd0, green: 3'd0, blue: 2'd0};
	localparam rgb_t colour_white      = '{red: 3'd7, green: 3'd7, blue: 2'd3};
	localparam rgb_t colour_grass      = '{red: 3'd0, green: 3'd2, blue: 2'd0};
	localparam rgb_t colour_obstacle   = '{red: 3'd5, green: 3'd0, blue: 2'd0};
	localparam rgb_t colour_car        = '{red: 3'd5, green: 3'd5, blue: 2'd0};
	localparam rgb_t colour_score_play = '{red: 3'd0, green: 3'd0, blue: 2'd3};
	localparam rgb_t colour_score_over = '{red: 3'd0, green: 3'd5, blue: 2'd0};

	// lane index to left edge
	function automatic coord_t lane_x_of(input int unsigned lane);
		case (lane)
			0:       return lane_x_0;
			1:       return lane_x_1;
			default: return lane_x_2;
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== src/traffic_dispatcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module traffic_dispatcher (
	input  logic                          clk,
	input  logic                          reset,
	input  lane_pkg::game_state_e         state,
	input  logic [lane_pkg::num_slots-1:0] handoff,
	output logic [lane_pkg::num_slots-1:0] spawn
);

	logic                          was_play;
	logic                          enter_play;
	logic [lane_pkg::num_slots-1:0] next_spawn;

	assign enter_play = (state == lane_pkg::game_play) && !was_play;

	// each handoff launches the following slot, slot 0 starts the chain
	always_comb begin
		next_spawn = {handoff[lane_pkg::num_slots-2:0], handoff[lane_pkg::num_slots-1]};
		next_spawn[0] = next_spawn[0] | enter_play;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			was_play <= 1'b0;
			spawn    <= '0;
		end else begin
			was_play <= (state == lane_pkg::game_play);
			if (state == lane_pkg::game_play) begin
				spawn <= next_spawn;
			end else begin
				spawn <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/obstacle_slot.sv ====
`timescale 1ns/1ps
`default_nettype none

module obstacle_slot #(
	parameter int initial_lane = 0
) (
	input  logic                  clk,
	input  logic                  reset,
	input  lane_pkg::game_state_e state,
	input  logic                  frame_tick,
	input  logic                  spawn,
	output lane_pkg::obstacle_t   obst,
	output logic                  handoff
);

	logic                                 active;
	logic [1:0]                           lane;
	lane_pkg::coord_t                     top;
	lane_pkg::coord_t                     next_top;
	logic [lane_pkg::frame_div_width-1:0] frame_div;
	logic                                 frame_due;

	assign next_top  = top + lane_pkg::obstacle_step;
	assign frame_due = (frame_div == lane_pkg::frames_per_step - 1);

	assign obst.active = active;
	assign obst.lane_x = lane_pkg::lane_x_of(lane);
	assign obst.top    = top;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			active    <= 1'b0;
			lane      <= 2'(initial_lane);
			top       <= '0;
			frame_div <= '0;
			handoff   <= 1'b0;
		end else begin
			handoff <= 1'b0;
			if (state == lane_pkg::game_over) begin
				active <= 1'b0;
			end else if (spawn) begin
				active    <= 1'b1;
				top       <= '0;
				frame_div <= '0;
			end else if (active && frame_tick && state == lane_pkg::game_play) begin
				if (frame_due) begin
					frame_div <= '0;
					top       <= next_top;
					// next car in the chain
					if (next_top == lane_pkg::handoff_top) begin
						handoff <= 1'b1;
					end
					// off the bottom, move over a lane for next time
					if (next_top == lane_pkg::retire_top) begin
						active <= 1'b0;
						lane   <= (lane == 2'd2) ? 2'd0 : lane + 2'd1;
					end
				end else begin
					frame_div <= frame_div + 1'b1;
				end
			end
		end
	end

	// chain spacing must retire a car before its slot comes round again
	a_spawn_idle: assert property (@(posedge clk) disable iff (reset)
		spawn |-> !active);

endmodule

`default_nettype wire

// ==== src/player_car.sv ====
`timescale 1ns/1ps
`default_nettype none

module player_car (
	input  logic                  clk,
	input  logic                  reset,
	input  lane_pkg::game_state_e state,
	input  logic                  frame_tick,
	input  logic                  steer_left,
	input  logic                  steer_right,
	output lane_pkg::coord_t      car_x
);

	logic [1:0]       target;
	lane_pkg::coord_t target_x;

	assign target_x = lane_pkg::lane_x_of(target);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			target <= 2'd1;
			car_x  <= lane_pkg::lane_x_1;
		end else begin
			// clamp at the outer lanes
			if (steer_left && !steer_right && target != 2'd0) begin
				target <= target - 2'd1;
			end else if (steer_right && !steer_left && target != 2'd2) begin
				target <= target + 2'd1;
			end

			// glide toward the target lane
			if (frame_tick && state == lane_pkg::game_play) begin
				if (car_x < target_x) begin
					car_x <= car_x + lane_pkg::steer_step;
				end else if (car_x > target_x) begin
					car_x <= car_x - lane_pkg::steer_step;
				end
			end
		end
	end

	a_car_on_road: assert property (@(posedge clk) disable iff (reset)
		car_x >= lane_pkg::lane_x_0 && car_x <= lane_pkg::lane_x_2);

endmodule

`default_nettype wire

// ==== src/game_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_fsm (
	input  logic                                          clk,
	input  logic                                          reset,
	input  logic                                          start,
	input  logic                                          frame_tick,
	input  lane_pkg::obstacle_t [lane_pkg::num_slots-1:0] obst,
	input  lane_pkg::coord_t                              car_x,
	output lane_pkg::game_state_e                         state
);

	logic crash;

	// inclusive rectangle overlap, car against every live obstacle
	always_comb begin
		crash = 1'b0;
		for (int i = 0; i < lane_pkg::num_slots; i++) begin
			if (obst[i].active
					&& obst[i].lane_x <= car_x + lane_pkg::car_width
					&& car_x <= obst[i].lane_x + lane_pkg::car_width
					&& obst[i].top <= lane_pkg::player_bottom
					&& lane_pkg::player_top <= obst[i].top + lane_pkg::obstacle_height) begin
				crash = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= lane_pkg::game_idle;
		end else begin
			case (state)
				lane_pkg::game_idle: begin
					if (start) begin
						state <= lane_pkg::game_play;
					end
				end
				lane_pkg::game_play: begin
					if (frame_tick && crash) begin
						state <= lane_pkg::game_over;
					end
				end
				// stays over until reset
				default: begin
					state <= lane_pkg::game_over;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/score_keeper.sv ====
`timescale 1ns/1ps
`default_nettype none

module score_keeper (
	input  logic                  clk,
	input  logic                  reset,
	input  lane_pkg::game_state_e state,
	input  logic                  score_tick,
	input  lane_pkg::pixel_req_t  pix,
	output lane_pkg::bcd_score_t  score,
	output logic                  seg_hit
);

	lane_pkg::bcd_score_t next_score;
	logic                 carry;
	lane_pkg::coord_t     left;

	// segments a..g on bits 6..0
	function automatic logic [6:0] seg_lut(input logic [3:0] digit);
		case (digit)
			4'd0:    return 7'b1111110;
			4'd1:    return 7'b0110000;
			4'd2:    return 7'b1101101;
			4'd3:    return 7'b1111001;
			4'd4:    return 7'b0110011;
			4'd5:    return 7'b1011011;
			4'd6:    return 7'b1011111;
			4'd7:    return 7'b1110000;
			4'd8:    return 7'b1111111;
			4'd9:    return 7'b1111011;
			default: return 7'b0000000;
		endcase
	endfunction

	function automatic logic stroke_hit(
		input lane_pkg::coord_t x,
		input lane_pkg::coord_t y,
		input lane_pkg::coord_t x0,
		input logic [6:0]       segs
	);
		lane_pkg::coord_t x1;
		lane_pkg::coord_t y0;
		lane_pkg::coord_t ym;
		lane_pkg::coord_t y1;
		logic             across;
		logic             upper;
		logic             lower;
		x1     = x0 + lane_pkg::digit_width;
		y0     = lane_pkg::digit_top;
		ym     = y0 + (lane_pkg::digit_height >> 1);
		y1     = y0 + lane_pkg::digit_height;
		across = (x >= x0) && (x <= x1);
		upper  = (y >= y0) && (y <= ym);
		lower  = (y >= ym) && (y <= y1);
		return (segs[6] && across && y == y0)
			|| (segs[5] && upper && x == x1)
			|| (segs[4] && lower && x == x1)
			|| (segs[3] && across && y == y1)
			|| (segs[2] && lower && x == x0)
			|| (segs[1] && upper && x == x0)
			|| (segs[0] && across && y == ym);
	endfunction

	////////////////////////////////////////////////////////////
	// decimal counter
	////////////////////////////////////////////////////////////

	always_comb begin
		carry      = 1'b1;
		next_score = score;
		for (int d = 0; d < lane_pkg::num_digits; d++) begin
			if (carry) begin
				if (score[d] == 4'd9) begin
					next_score[d] = 4'd0;
				end else begin
					next_score[d] = score[d] + 4'd1;
					carry         = 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			score <= '0;
		end else if (score_tick && state == lane_pkg::game_play) begin
			score <= next_score;
		end
	end

	////////////////////////////////////////////////////////////
	// segment pixels
	////////////////////////////////////////////////////////////

	always_comb begin
		seg_hit = 1'b0;
		left    = lane_pkg::digit_x0;
		// leftmost box holds the top digit
		for (int d = lane_pkg::num_digits - 1; d >= 0; d--) begin
			if (stroke_hit(pix.hcount, pix.vcount, left, seg_lut(score[d]))) begin
				seg_hit = 1'b1;
			end
			left = left + lane_pkg::digit_pitch;
		end
	end

	a_bcd_digits: assert property (@(posedge clk) disable iff (reset)
		score[3] <= 4'd9 && score[2] <= 4'd9 && score[1] <= 4'd9 && score[0] <= 4'd9);

endmodule

`default_nettype wire

// ==== src/pixel_compositor.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_compositor (
	input  logic                                          clk,
	input  logic                                          reset,
	input  lane_pkg::pixel_req_t                          pix,
	input  lane_pkg::game_state_e                         state,
	input  lane_pkg::obstacle_t [lane_pkg::num_slots-1:0] obst,
	input  lane_pkg::coord_t                              car_x,
	input  logic                                          seg_hit,
	output lane_pkg::rgb_t                                rgb
);

	logic           obst_hit;
	logic           car_hit;
	logic           divider_hit;
	logic           grass_hit;
	lane_pkg::rgb_t colour;

	always_comb begin
		obst_hit = 1'b0;
		for (int i = 0; i < lane_pkg::num_slots; i++) begin
			if (obst[i].active
					&& pix.hcount >= obst[i].lane_x
					&& pix.hcount <= obst[i].lane_x + lane_pkg::car_width
					&& pix.vcount >= obst[i].top
					&& pix.vcount <= obst[i].top + lane_pkg::obstacle_height) begin
				obst_hit = 1'b1;
			end
		end
	end

	assign car_hit = pix.hcount >= car_x && pix.hcount <= car_x + lane_pkg::car_width
		&& pix.vcount >= lane_pkg::player_top && pix.vcount <= lane_pkg::player_bottom;

	// solid stripes, full height
	assign divider_hit =
		(pix.hcount >= lane_pkg::divider_0_left && pix.hcount <= lane_pkg::divider_0_right)
		|| (pix.hcount >= lane_pkg::divider_1_left && pix.hcount <= lane_pkg::divider_1_right);

	assign grass_hit = pix.hcount < lane_pkg::road_left || pix.hcount > lane_pkg::road_right;

	// highest priority first
	always_comb begin
		colour = lane_pkg::colour_black;
		if (pix.blank || state == lane_pkg::game_idle) begin
			colour = lane_pkg::colour_black;
		end else if (state == lane_pkg::game_over) begin
			if (seg_hit) begin
				colour = lane_pkg::colour_score_over;
			end
		end else if (seg_hit) begin
			colour = lane_pkg::colour_score_play;
		end else if (car_hit) begin
			colour = lane_pkg::colour_car;
		end else if (obst_hit) begin
			colour = lane_pkg::colour_obstacle;
		end else if (divider_hit) begin
			colour = lane_pkg::colour_white;
		end else if (grass_hit) begin
			colour = lane_pkg::colour_grass;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rgb <= lane_pkg::colour_black;
		end else begin
			rgb <= colour;
		end
	end

endmodule

`default_nettype wire

// ==== src/lane_splitter_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_splitter_top (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  start,
	input  logic                  steer_left,
	input  logic                  steer_right,
	input  logic                  frame_tick,
	input  logic                  score_tick,
	input  lane_pkg::pixel_req_t  pix,
	output lane_pkg::rgb_t        rgb,
	output lane_pkg::game_state_e state,
	output lane_pkg::bcd_score_t  score
);

	logic [lane_pkg::num_slots-1:0]                spawn;
	logic [lane_pkg::num_slots-1:0]                handoff;
	lane_pkg::obstacle_t [lane_pkg::num_slots-1:0] obst;
	lane_pkg::coord_t                              car_x;
	logic                                          seg_hit;

	game_fsm u_game_fsm (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.frame_tick (frame_tick),
		.obst       (obst),
		.car_x      (car_x),
		.state      (state)
	);

	traffic_dispatcher u_dispatcher (
		.clk     (clk),
		.reset   (reset),
		.state   (state),
		.handoff (handoff),
		.spawn   (spawn)
	);

	// one slot per lane at start, rotating afterwards
	for (genvar i = 0; i < lane_pkg::num_slots; i++) begin : g_slot
		obstacle_slot #(
			.initial_lane (i)
		) u_slot (
			.clk        (clk),
			.reset      (reset),
			.state      (state),
			.frame_tick (frame_tick),
			.spawn      (spawn[i]),
			.obst       (obst[i]),
			.handoff    (handoff[i])
		);
	end

	player_car u_player (
		.clk         (clk),
		.reset       (reset),
		.state       (state),
		.frame_tick  (frame_tick),
		.steer_left  (steer_left),
		.steer_right (steer_right),
		.car_x       (car_x)
	);

	score_keeper u_score (
		.clk        (clk),
		.reset      (reset),
		.state      (state),
		.score_tick (score_tick),
		.pix        (pix),
		.score      (score),
		.seg_hit    (seg_hit)
	);

	pixel_compositor u_compositor (
		.clk     (clk),
		.reset   (reset),
		.pix     (pix),
		.state   (state),
		.obst    (obst),
		.car_x   (car_x),
		.seg_hit (seg_hit),
		.rgb     (rgb)
	);

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== bench/lane_splitter_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_splitter_tb;

	typedef struct packed {
		logic                  start;
		logic                  steer_right;
		logic [7:0]            score_ticks;
		logic [7:0]            frames;
		logic                  wait_over;
		logic [10:0]           probe_x;
		logic [10:0]           probe_y;
		logic                  probe_blank;
		logic [3:0]            rand_probes;
		lane_pkg::game_state_e exp_state;
		lane_pkg::bcd_score_t  exp_score;
	} step_t;

	logic                  clk;
	logic                  reset;
	logic                  start;
	logic                  steer_left;
	logic                  steer_right;
	logic                  frame_tick;
	logic                  score_tick;
	lane_pkg::pixel_req_t  pix;
	lane_pkg::rgb_t        rgb;
	lane_pkg::game_state_e state;
	lane_pkg::bcd_score_t  score;

	step_t  steps [13];
	string  step_name [13];
	int     step_errors;
	integer seed;

	// reference model of the game
	lane_pkg::game_state_e m_state;
	int   m_score;
	int   m_car_x;
	int   m_target;
	int   m_top [lane_pkg::num_slots];
	int   m_lane [lane_pkg::num_slots];
	int   m_div [lane_pkg::num_slots];
	logic m_active [lane_pkg::num_slots];

	tb_clock_gen u_clock (
		.clk   (clk),
		.reset (reset)
	);

	lane_splitter_top dut (
		.clk         (clk),
		.reset       (reset),
		.start       (start),
		.steer_left  (steer_left),
		.steer_right (steer_right),
		.frame_tick  (frame_tick),
		.score_tick  (score_tick),
		.pix         (pix),
		.rgb         (rgb),
		.state       (state),
		.score       (score)
	);

	////////////////////////////////////////////////////////////
	// reference rules
	////////////////////////////////////////////////////////////

	// lanes are 100 pixels apart
	function automatic int lane_left(input int lane);
		return lane_pkg::lane_x_0 + lane * (lane_pkg::lane_x_1 - lane_pkg::lane_x_0);
	endfunction

	function automatic logic in_rect(input int x, input int y, input int l, input int t,
			input int w, input int h);
		return x >= l && x <= l + w && y >= t && y <= t + h;
	endfunction

	// bit n of each mask is digit n, segments a..g
	function automatic logic seg_lit(input int digit, input int s);
		logic [9:0] mask;
		case (s)
			0:       mask = 10'b11_1110_1101;
			1:       mask = 10'b11_1001_1111;
			2:       mask = 10'b11_1111_1011;
			3:       mask = 10'b11_0110_1101;
			4:       mask = 10'b01_0100_0101;
			5:       mask = 10'b11_0111_0001;
			default: mask = 10'b11_0111_1100;
		endcase
		return mask[digit];
	endfunction

	function automatic logic on_stroke(input int s, input int x, input int y, input int x0);
		int   x1;
		int   y0;
		int   ym;
		int   y1;
		logic across;
		logic upper;
		logic lower;
		x1     = x0 + lane_pkg::digit_width;
		y0     = lane_pkg::digit_top;
		ym     = y0 + lane_pkg::digit_height / 2;
		y1     = y0 + lane_pkg::digit_height;
		across = x >= x0 && x <= x1;
		upper  = y >= y0 && y <= ym;
		lower  = y >= ym && y <= y1;
		case (s)
			0:       return across && y == y0;
			1:       return upper && x == x1;
			2:       return lower && x == x1;
			3:       return across && y == y1;
			4:       return lower && x == x0;
			5:       return upper && x == x0;
			default: return across && y == ym;
		endcase
	endfunction

	function automatic logic seg_pixel(input int x, input int y);
		logic hit;
		int   weight;
		int   x0;
		hit    = 1'b0;
		weight = 1;
		for (int d = 0; d < 4; d++) begin
			x0 = lane_pkg::digit_x0 + (3 - d) * lane_pkg::digit_pitch;
			for (int s = 0; s < 7; s++) begin
				if (seg_lit((m_score / weight) % 10, s) && on_stroke(s, x, y, x0)) begin
					hit = 1'b1;
				end
			end
			weight = weight * 10;
		end
		return hit;
	endfunction

	function automatic lane_pkg::rgb_t ref_colour(input int x, input int y, input logic blank);
		logic obst;
		obst = 1'b0;
		for (int i = 0; i < lane_pkg::num_slots; i++) begin
			if (m_active[i] && in_rect(x, y, lane_left(m_lane[i]), m_top[i],
					lane_pkg::car_width, lane_pkg::obstacle_height)) begin
				obst = 1'b1;
			end
		end
		if (blank || m_state == lane_pkg::game_idle) begin
			return lane_pkg::colour_black;
		end else if (m_state == lane_pkg::game_over) begin
			return seg_pixel(x, y) ? lane_pkg::colour_score_over : lane_pkg::colour_black;
		end else if (seg_pixel(x, y)) begin
			return lane_pkg::colour_score_play;
		end else if (in_rect(x, y, m_car_x, lane_pkg::player_top, lane_pkg::car_width,
				lane_pkg::player_bottom - lane_pkg::player_top)) begin
			return lane_pkg::colour_car;
		end else if (obst) begin
			return lane_pkg::colour_obstacle;
		end else if ((x >= 265 && x <= 275) || (x >= 365 && x <= 375)) begin
			return lane_pkg::colour_white;
		end else if (x < lane_pkg::road_left || x > lane_pkg::road_right) begin
			return lane_pkg::colour_grass;
		end
		return lane_pkg::colour_black;
	endfunction

	function automatic void model_reset();
		m_state  = lane_pkg::game_idle;
		m_score  = 0;
		m_car_x  = lane_pkg::lane_x_1;
		m_target = 1;
		for (int i = 0; i < lane_pkg::num_slots; i++) begin
			m_active[i] = 1'b0;
			m_lane[i]   = i;
			m_top[i]    = 0;
			m_div[i]    = 0;
		end
	endfunction

	function automatic void model_frame();
		logic       crashed;
		logic [2:0] handed;
		int         goal;
		if (m_state != lane_pkg::game_play) begin
			return;
		end
		crashed = 1'b0;
		handed  = '0;
		for (int i = 0; i < lane_pkg::num_slots; i++) begin
			if (m_active[i] && lane_left(m_lane[i]) <= m_car_x + lane_pkg::car_width
					&& m_car_x <= lane_left(m_lane[i]) + lane_pkg::car_width
					&& m_top[i] <= lane_pkg::player_bottom
					&& lane_pkg::player_top <= m_top[i] + lane_pkg::obstacle_height) begin
				crashed = 1'b1;
			end
		end
		goal = lane_left(m_target);
		if (m_car_x < goal) begin
			m_car_x = m_car_x + lane_pkg::steer_step;
		end else if (m_car_x > goal) begin
			m_car_x = m_car_x - lane_pkg::steer_step;
		end
		for (int i = 0; i < lane_pkg::num_slots; i++) begin
			if (m_active[i] && m_div[i] == lane_pkg::frames_per_step - 1) begin
				m_div[i] = 0;
				m_top[i] = m_top[i] + lane_pkg::obstacle_step;
				handed[i] = (m_top[i] == lane_pkg::handoff_top);
				if (m_top[i] == lane_pkg::retire_top) begin
					m_active[i] = 1'b0;
					m_lane[i]   = (m_lane[i] + 1) % 3;
				end
			end else if (m_active[i]) begin
				m_div[i] = m_div[i] + 1;
			end
		end
		for (int i = 0; i < lane_pkg::num_slots; i++) begin
			if (crashed) begin
				m_active[i] = 1'b0;
			end else if (handed[i]) begin
				m_active[(i + 1) % 3] = 1'b1;
				m_top[(i + 1) % 3]    = 0;
				m_div[(i + 1) % 3]    = 0;
			end
		end
		if (crashed) begin
			m_state = lane_pkg::game_over;
		end
	endfunction

	////////////////////////////////////////////////////////////
	// driving and checking
	////////////////////////////////////////////////////////////

	// bits are start, steer_left, steer_right, score_tick, frame_tick
	task automatic strobe(input logic [4:0] bits);
		@(posedge clk);
		{start, steer_left, steer_right, score_tick, frame_tick} <= bits;
		@(posedge clk);
		{start, steer_left, steer_right, score_tick, frame_tick} <= 5'b0;
		// room for handoff to reach the next slot
		repeat (3) @(posedge clk);
	endtask

	task automatic compare_values(input string test, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s: %s expected %0h, actual %0h", test, what, expected, actual);
			step_errors++;
		end
	endtask

	task automatic probe(input string test, input int x, input int y, input logic blank);
		lane_pkg::rgb_t expected;
		@(posedge clk);
		pix <= {11'(x), 11'(y), blank};
		@(posedge clk);
		@(negedge clk);
		expected = ref_colour(x, y, blank);
		compare_values(test, $sformatf("rgb at %0d,%0d", x, y), expected, rgb);
	endtask

	initial begin
		int          n;
		int          passed;
		int          failed;
		logic        run_failed;
		logic [31:0] rnd;
		step_t       st;
		start       = 1'b0;
		steer_left  = 1'b0;
		steer_right = 1'b0;
		frame_tick  = 1'b0;
		score_tick  = 1'b0;
		pix         = '0;
		seed        = 32'h706d_80e3;
		passed      = 0;
		failed      = 0;
		run_failed  = 1'b0;

		// start, steer, score ticks, frames, wait, x, y, blank, random probes, state, score
		steps[0]  = '{0, 0, 0, 0, 0, 100, 100, 0, 8, lane_pkg::game_idle, 16'h0000};
		steps[1]  = '{1, 0, 0, 0, 0, 100, 200, 0, 8, lane_pkg::game_play, 16'h0000};
		steps[2]  = '{0, 0, 0, 0, 0, 100, 200, 1, 0, lane_pkg::game_play, 16'h0000};
		steps[3]  = '{0, 0, 0, 0, 0, 220, 300, 0, 4, lane_pkg::game_play, 16'h0000};
		steps[4]  = '{0, 0, 0, 0, 0, 270, 200, 0, 0, lane_pkg::game_play, 16'h0000};
		steps[5]  = '{0, 0, 0, 0, 0, 320, 440, 0, 0, lane_pkg::game_play, 16'h0000};
		steps[6]  = '{0, 0, 99, 0, 0, 80, 15, 0, 4, lane_pkg::game_play, 16'h0099};
		steps[7]  = '{0, 0, 1, 0, 0, 50, 15, 0, 4, lane_pkg::game_play, 16'h0100};
		steps[8]  = '{0, 1, 0, 20, 0, 420, 440, 0, 4, lane_pkg::game_play, 16'h0100};
		steps[9]  = '{0, 0, 0, 0, 0, 320, 440, 0, 0, lane_pkg::game_play, 16'h0100};
		steps[10] = '{0, 0, 0, 10, 0, 210, 80, 0, 4, lane_pkg::game_play, 16'h0100};
		steps[11] = '{0, 0, 0, 0, 1, 75, 10, 0, 4, lane_pkg::game_over, 16'h0100};
		steps[12] = '{0, 0, 5, 0, 0, 40, 15, 0, 8, lane_pkg::game_over, 16'h0100};
		step_name = '{"reset_idle", "start_grass", "blank_black", "road_black",
			"divider_white", "car_yellow", "score_0099", "score_0100", "steer_right",
			"old_lane_road", "obstacle_red", "crash_over", "score_frozen"};

		model_reset();
		for (n = 0; n < 40 && reset !== 1'b0; n++) begin
			@(posedge clk);
		end
		if (reset !== 1'b0) begin
			$display("reset was never released");
			run_failed = 1'b1;
		end

		for (int s = 0; s < 13; s++) begin
			st          = steps[s];
			step_errors = 0;
			if (st.start) begin
				strobe(5'b10000);
				if (m_state == lane_pkg::game_idle) begin
					m_state     = lane_pkg::game_play;
					m_active[0] = 1'b1;
				end
			end
			if (st.steer_right) begin
				strobe(5'b00100);
				m_target = (m_target < 2) ? m_target + 1 : m_target;
			end
			repeat (st.score_ticks) begin
				strobe(5'b00010);
				if (m_state == lane_pkg::game_play) begin
					m_score = (m_score + 1) % 10000;
				end
			end
			repeat (st.frames) begin
				strobe(5'b00001);
				model_frame();
			end
			if (st.wait_over) begin
				for (n = 0; n < 400 && state != lane_pkg::game_over; n++) begin
					strobe(5'b00001);
					model_frame();
				end
				if (state != lane_pkg::game_over) begin
					$display("timeout while waiting for the crash in step %s", step_name[s]);
					step_errors++;
				end
				compare_values(step_name[s], "model state", m_state, state);
			end
			compare_values(step_name[s], "state", st.exp_state, state);
			compare_values(step_name[s], "score", st.exp_score, score);
			probe(step_name[s], st.probe_x, st.probe_y, st.probe_blank);
			repeat (st.rand_probes) begin
				rnd = $random(seed);
				n   = int'(rnd % 640);
				rnd = $random(seed);
				probe(step_name[s], n, int'(rnd % 480), 1'b0);
			end
			if (step_errors == 0) begin
				$display("[PASS] %s", step_name[s]);
				passed++;
			end else begin
				$display("[FAIL] %s", step_name[s]);
				failed++;
			end
		end

		$display("steps passed: %0d, steps failed: %0d", passed, failed);
		if (failed == 0 && !run_failed) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
src/lane_pkg.sv
src/traffic_dispatcher.sv
src/obstacle_slot.sv
src/player_car.sv
src/game_fsm.sv
src/score_keeper.sv
src/pixel_compositor.sv
src/lane_splitter_top.sv
bench/tb_clock_gen.sv
bench/lane_splitter_tb.sv

// ==== Bender.yml ====
package:
  name: lane_splitter

sources:
  - src/lane_pkg.sv
  - src/traffic_dispatcher.sv
  - src/obstacle_slot.sv
  - src/player_car.sv
  - src/game_fsm.sv
  - src/score_keeper.sv
  - src/pixel_compositor.sv
  - src/lane_splitter_top.sv
  - target: simulation
    files:
      - bench/tb_clock_gen.sv
      - bench/lane_splitter_tb.sv
